// File: hdl/alu_unit.sv
module alu_unit
  import core_pkg::*;
(
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    iss_valid,
  input  logic [rob_idx_size-1:0] iss_tag,
  input  alu_op_t                 iss_op,
  input  logic [gpr_size-1:0]     iss_a,
  input  logic [gpr_size-1:0]     iss_b,
  input  logic                    iss_carry,
  output logic                    res_valid,
  output logic [rob_idx_size-1:0] res_tag,
  output logic [gpr_size-1:0]     res_value,
  output logic [nzcv_size-1:0]    res_nzcv
);

  logic [gpr_size-1:0] b_eff;
  logic [gpr_size-1:0] result;
  logic [gpr_size:0]   sum;
  logic                cin;
  logic                arith;
  logic                carry;
  logic                overflow;

  always_comb begin
    // SUB is A + ~B + 1, so carry out means no borrow
    b_eff = (iss_op == OP_SUB) ? ~iss_b : iss_b;
    cin   = (iss_op == OP_SUB) || (iss_op == OP_ADC && iss_carry);
    sum   = {1'b0, iss_a} + {1'b0, b_eff} + {{gpr_size{1'b0}}, cin};
    arith = 1'b0;
    case (iss_op)
      OP_ADD, OP_SUB, OP_ADC: begin
        result = sum[gpr_size-1:0];
        arith  = 1'b1;
      end
      OP_AND:  result = iss_a & iss_b;
      OP_ORR:  result = iss_a | iss_b;
      OP_EOR:  result = iss_a ^ iss_b;
      default: result = iss_b;  // MOV
    endcase
    carry    = arith && sum[gpr_size];
    overflow = arith && (iss_a[gpr_size-1] == b_eff[gpr_size-1]) &&
               (result[gpr_size-1] != iss_a[gpr_size-1]);
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      res_valid <= 1'b0;
    end else begin
      res_valid <= iss_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (iss_valid) begin
      res_tag   <= iss_tag;
      res_value <= result;
      res_nzcv  <= {result[gpr_size-1], result == '0, carry, overflow};
    end
  end

endmodule

// File: hdl/core_pkg.sv
package core_pkg;

  // Register file geometry
  localparam int gpr_count    = 8;
  localparam int gpr_idx_size = 3;
  localparam int gpr_size     = 32;
  localparam int imm_size     = 16;

  // Reorder buffer geometry
  localparam int rob_depth    = 8;
  localparam int rob_idx_size = 3;

  // Entries kept back for the words still in decode and rename
  localparam int rob_reserve  = 2;

  localparam int instr_size   = 32;
  localparam int op_size      = 4;

  // Flags packed as {N, Z, C, V}
  localparam int nzcv_size    = 4;
  localparam int nzcv_c_bit   = 1;

  // Instruction field positions
  localparam int opc_lsb      = 28;
  localparam int set_nzcv_bit = 27;
  localparam int use_imm_bit  = 26;
  localparam int dst_lsb      = 23;
  localparam int src1_lsb     = 20;
  localparam int src2_lsb     = 17;

  typedef enum logic [op_size-1:0] {
    OP_ADD = 4'd0,
    OP_SUB = 4'd1,
    OP_AND = 4'd2,
    OP_ORR = 4'd3,
    OP_EOR = 4'd4,
    OP_MOV = 4'd5,
    OP_ADC = 4'd6
  } alu_op_t;

  typedef enum logic [1:0] {
    ROB_FREE   = 2'd0,
    ROB_WAIT   = 2'd1,
    ROB_ISSUED = 2'd2,
    ROB_DONE   = 2'd3
  } rob_state_t;

endpackage

// File: hdl/instr_decoder.sv
module instr_decoder
  import core_pkg::*;
(
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    instr_valid,
  input  logic [instr_size-1:0]   instr,
  output logic                    dec_valid,
  output alu_op_t                 op,
  output logic                    set_nzcv,
  output logic                    use_imm,
  output logic [imm_size-1:0]     imm,
  output logic [gpr_idx_size-1:0] src1,
  output logic [gpr_idx_size-1:0] src2,
  output logic [gpr_idx_size-1:0] dst,
  output logic                    uses_nzcv
);

  alu_op_t raw_op;
  logic    legal_op;

  always_comb begin
    raw_op = alu_op_t'(instr[opc_lsb +: op_size]);
    case (raw_op)
      OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_EOR, OP_MOV, OP_ADC: legal_op = 1'b1;
      default: legal_op = 1'b0;
    endcase
  end

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      dec_valid <= 1'b0;
    end else begin
      dec_valid <= instr_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (instr_valid) begin
      src1 <= instr[src1_lsb +: gpr_idx_size];
      src2 <= instr[src2_lsb +: gpr_idx_size];
      dst  <= instr[dst_lsb +: gpr_idx_size];
      if (legal_op) begin
        op        <= raw_op;
        set_nzcv  <= instr[set_nzcv_bit];
        use_imm   <= instr[use_imm_bit];
        imm       <= instr[imm_size-1:0];
        uses_nzcv <= (raw_op == OP_ADC);
      end else begin
        // Unknown opcode becomes MOV #0 and leaves the flags alone
        op        <= OP_MOV;
        set_nzcv  <= 1'b0;
        use_imm   <= 1'b1;
        imm       <= '0;
        uses_nzcv <= 1'b0;
      end
    end
  end

endmodule

// File: hdl/ooo_core_top.sv
module ooo_core_top
  import core_pkg::*;
(
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    instr_valid,
  input  logic [instr_size-1:0]   instr,
  output logic                    instr_ready,
  output logic                    commit_valid,
  output logic [gpr_idx_size-1:0] commit_reg,
  output logic [gpr_size-1:0]     commit_value,
  output logic                    commit_set_nzcv,
  output logic [nzcv_size-1:0]    commit_nzcv
);

  logic                    accept;
  // Decoder to rename
  logic                    dec_valid;
  alu_op_t                 dec_op;
  logic                    dec_set_nzcv;
  logic                    dec_use_imm;
  logic [imm_size-1:0]     dec_imm;
  logic [gpr_idx_size-1:0] dec_src1;
  logic [gpr_idx_size-1:0] dec_src2;
  logic [gpr_idx_size-1:0] dec_dst;
  logic                    dec_uses_nzcv;
  // Rename to reorder buffer
  logic                    ren_valid;
  logic                    src1_valid;
  logic [rob_idx_size-1:0] src1_tag;
  logic [gpr_size-1:0]     src1_value;
  logic                    src2_valid;
  logic [rob_idx_size-1:0] src2_tag;
  logic [gpr_size-1:0]     src2_value;
  logic                    nzcv_valid;
  logic [rob_idx_size-1:0] nzcv_tag;
  logic [nzcv_size-1:0]    nzcv_value;
  logic [gpr_idx_size-1:0] ren_dst;
  alu_op_t                 ren_op;
  logic                    ren_set_nzcv;
  logic                    ren_uses_nzcv;
  logic [rob_idx_size-1:0] next_tag;
  logic [rob_idx_size-1:0] commit_tag;
  // Issue and result
  logic                    iss_valid;
  logic [rob_idx_size-1:0] iss_tag;
  alu_op_t                 iss_op;
  logic [gpr_size-1:0]     iss_a;
  logic [gpr_size-1:0]     iss_b;
  logic                    iss_carry;
  logic                    res_valid;
  logic [rob_idx_size-1:0] res_tag;
  logic [gpr_size-1:0]     res_value;
  logic [nzcv_size-1:0]    res_nzcv;

  assign accept = instr_valid && instr_ready;

  instr_decoder u_decoder (
    .in_clk     (in_clk),
    .in_rst     (in_rst),
    .instr_valid(accept),
    .instr      (instr),
    .dec_valid  (dec_valid),
    .op         (dec_op),
    .set_nzcv   (dec_set_nzcv),
    .use_imm    (dec_use_imm),
    .imm        (dec_imm),
    .src1       (dec_src1),
    .src2       (dec_src2),
    .dst        (dec_dst),
    .uses_nzcv  (dec_uses_nzcv)
  );

  reg_rename u_rename (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .dec_valid      (dec_valid),
    .dec_op         (dec_op),
    .dec_set_nzcv   (dec_set_nzcv),
    .dec_use_imm    (dec_use_imm),
    .dec_imm        (dec_imm),
    .dec_src1       (dec_src1),
    .dec_src2       (dec_src2),
    .dec_dst        (dec_dst),
    .dec_uses_nzcv  (dec_uses_nzcv),
    .next_tag       (next_tag),
    .commit_valid   (commit_valid),
    .commit_tag     (commit_tag),
    .commit_reg     (commit_reg),
    .commit_value   (commit_value),
    .commit_set_nzcv(commit_set_nzcv),
    .commit_nzcv    (commit_nzcv),
    .ren_valid      (ren_valid),
    .src1_valid     (src1_valid),
    .src1_tag       (src1_tag),
    .src1_value     (src1_value),
    .src2_valid     (src2_valid),
    .src2_tag       (src2_tag),
    .src2_value     (src2_value),
    .nzcv_valid     (nzcv_valid),
    .nzcv_tag       (nzcv_tag),
    .nzcv_value     (nzcv_value),
    .dst            (ren_dst),
    .op             (ren_op),
    .set_nzcv       (ren_set_nzcv),
    .uses_nzcv      (ren_uses_nzcv)
  );

  reorder_buffer u_rob (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .ren_valid      (ren_valid),
    .src1_valid     (src1_valid),
    .src1_tag       (src1_tag),
    .src1_value     (src1_value),
    .src2_valid     (src2_valid),
    .src2_tag       (src2_tag),
    .src2_value     (src2_value),
    .nzcv_valid     (nzcv_valid),
    .nzcv_tag       (nzcv_tag),
    .nzcv_value     (nzcv_value),
    .dst            (ren_dst),
    .op             (ren_op),
    .set_nzcv       (ren_set_nzcv),
    .uses_nzcv      (ren_uses_nzcv),
    .res_valid      (res_valid),
    .res_tag        (res_tag),
    .res_value      (res_value),
    .res_nzcv       (res_nzcv),
    .next_tag       (next_tag),
    .instr_ready    (instr_ready),
    .iss_valid      (iss_valid),
    .iss_tag        (iss_tag),
    .iss_op         (iss_op),
    .iss_a          (iss_a),
    .iss_b          (iss_b),
    .iss_carry      (iss_carry),
    .commit_valid   (commit_valid),
    .commit_tag     (commit_tag),
    .commit_reg     (commit_reg),
    .commit_value   (commit_value),
    .commit_set_nzcv(commit_set_nzcv),
    .commit_nzcv    (commit_nzcv)
  );

  alu_unit u_alu (
    .in_clk   (in_clk),
    .in_rst   (in_rst),
    .iss_valid(iss_valid),
    .iss_tag  (iss_tag),
    .iss_op   (iss_op),
    .iss_a    (iss_a),
    .iss_b    (iss_b),
    .iss_carry(iss_carry),
    .res_valid(res_valid),
    .res_tag  (res_tag),
    .res_value(res_value),
    .res_nzcv (res_nzcv)
  );

endmodule

// File: hdl/reg_rename.sv
module reg_rename
  import core_pkg::*;
(
  input  logic                    in_clk,
  input  logic                    in_rst,
  // From decoder
  input  logic                    dec_valid,
  input  alu_op_t                 dec_op,
  input  logic                    dec_set_nzcv,
  input  logic                    dec_use_imm,
  input  logic [imm_size-1:0]     dec_imm,
  input  logic [gpr_idx_size-1:0] dec_src1,
  input  logic [gpr_idx_size-1:0] dec_src2,
  input  logic [gpr_idx_size-1:0] dec_dst,
  input  logic                    dec_uses_nzcv,
  // From reorder buffer
  input  logic [rob_idx_size-1:0] next_tag,
  input  logic                    commit_valid,
  input  logic [rob_idx_size-1:0] commit_tag,
  input  logic [gpr_idx_size-1:0] commit_reg,
  input  logic [gpr_size-1:0]     commit_value,
  input  logic                    commit_set_nzcv,
  input  logic [nzcv_size-1:0]    commit_nzcv,
  // To reorder buffer
  output logic                    ren_valid,
  output logic                    src1_valid,
  output logic [rob_idx_size-1:0] src1_tag,
  output logic [gpr_size-1:0]     src1_value,
  output logic                    src2_valid,
  output logic [rob_idx_size-1:0] src2_tag,
  output logic [gpr_size-1:0]     src2_value,
  output logic                    nzcv_valid,
  output logic [rob_idx_size-1:0] nzcv_tag,
  output logic [nzcv_size-1:0]    nzcv_value,
  output logic [gpr_idx_size-1:0] dst,
  output alu_op_t                 op,
  output logic                    set_nzcv,
  output logic                    uses_nzcv
);

  // Status table
  logic [gpr_size-1:0]     reg_value [gpr_count];
  logic [gpr_count-1:0]    reg_valid;
  logic [rob_idx_size-1:0] reg_tag   [gpr_count];
  logic [nzcv_size-1:0]    flag_value;
  logic                    flag_valid;
  logic [rob_idx_size-1:0] flag_tag;

  logic [gpr_idx_size-1:0] src1_q;
  logic [gpr_idx_size-1:0] src2_q;
  logic                    use_imm_q;
  logic [imm_size-1:0]     imm_q;
  logic                    src1_fwd;
  logic                    src2_fwd;
  logic                    flag_fwd;

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      ren_valid <= 1'b0;
    end else begin
      ren_valid <= dec_valid;
    end
  end

  always_ff @(posedge in_clk) begin
    if (dec_valid) begin
      src1_q    <= dec_src1;
      src2_q    <= dec_src2;
      use_imm_q <= dec_use_imm;
      imm_q     <= dec_imm;
      dst       <= dec_dst;
      op        <= dec_op;
      set_nzcv  <= dec_set_nzcv;
      uses_nzcv <= dec_uses_nzcv;
    end
  end

  // Commit first, a rename of the same register overrides it
  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < gpr_count; i++) begin
        reg_value[i] <= '0;
        reg_tag[i]   <= '0;
      end
      reg_valid  <= '1;
      flag_value <= '0;
      flag_valid <= 1'b1;
      flag_tag   <= '0;
    end else begin
      // Superseded producers do not write back
      if (commit_valid && commit_tag == reg_tag[commit_reg]) begin
        reg_value[commit_reg] <= commit_value;
        reg_valid[commit_reg] <= 1'b1;
      end
      if (flag_fwd) begin
        flag_value <= commit_nzcv;
        flag_valid <= 1'b1;
      end
      if (ren_valid) begin
        reg_valid[dst] <= 1'b0;
        reg_tag[dst]   <= next_tag;
        if (set_nzcv) begin
          flag_valid <= 1'b0;
          flag_tag   <= next_tag;
        end
      end
    end
  end

  // Operand read with bypass of a same-cycle commit
  always_comb begin
    src1_fwd = commit_valid && commit_reg == src1_q && commit_tag == reg_tag[src1_q];
    src2_fwd = commit_valid && commit_reg == src2_q && commit_tag == reg_tag[src2_q];
    flag_fwd = commit_valid && commit_set_nzcv && commit_tag == flag_tag;

    src1_valid = reg_valid[src1_q] || src1_fwd;
    src1_tag   = reg_tag[src1_q];
    src1_value = src1_fwd ? commit_value : reg_value[src1_q];

    src2_tag = reg_tag[src2_q];
    if (use_imm_q) begin
      src2_valid = 1'b1;
      src2_value = {{(gpr_size - imm_size){1'b0}}, imm_q};
    end else begin
      src2_valid = reg_valid[src2_q] || src2_fwd;
      src2_value = src2_fwd ? commit_value : reg_value[src2_q];
    end

    nzcv_valid = flag_valid || flag_fwd;
    nzcv_tag   = flag_tag;
    nzcv_value = flag_fwd ? commit_nzcv : flag_value;
  end

  // A commit carrying the recorded producer must find its register pending
  a_commit_pending : assert property (@(posedge in_clk) disable iff (in_rst)
    commit_valid && commit_tag == reg_tag[commit_reg] |-> !reg_valid[commit_reg]);

endmodule

// File: hdl/reorder_buffer.sv
module reorder_buffer
  import core_pkg::*;
(
  input  logic                    in_clk,
  input  logic                    in_rst,
  // Dispatch from rename
  input  logic                    ren_valid,
  input  logic                    src1_valid,
  input  logic [rob_idx_size-1:0] src1_tag,
  input  logic [gpr_size-1:0]     src1_value,
  input  logic                    src2_valid,
  input  logic [rob_idx_size-1:0] src2_tag,
  input  logic [gpr_size-1:0]     src2_value,
  input  logic                    nzcv_valid,
  input  logic [rob_idx_size-1:0] nzcv_tag,
  input  logic [nzcv_size-1:0]    nzcv_value,
  input  logic [gpr_idx_size-1:0] dst,
  input  alu_op_t                 op,
  input  logic                    set_nzcv,
  input  logic                    uses_nzcv,
  // Result broadcast
  input  logic                    res_valid,
  input  logic [rob_idx_size-1:0] res_tag,
  input  logic [gpr_size-1:0]     res_value,
  input  logic [nzcv_size-1:0]    res_nzcv,
  output logic [rob_idx_size-1:0] next_tag,
  output logic                    instr_ready,
  // Issue
  output logic                    iss_valid,
  output logic [rob_idx_size-1:0] iss_tag,
  output alu_op_t                 iss_op,
  output logic [gpr_size-1:0]     iss_a,
  output logic [gpr_size-1:0]     iss_b,
  output logic                    iss_carry,
  // Commit
  output logic                    commit_valid,
  output logic [rob_idx_size-1:0] commit_tag,
  output logic [gpr_idx_size-1:0] commit_reg,
  output logic [gpr_size-1:0]     commit_value,
  output logic                    commit_set_nzcv,
  output logic [nzcv_size-1:0]    commit_nzcv
);

  rob_state_t              state       [rob_depth];
  alu_op_t                 e_op        [rob_depth];
  logic [gpr_idx_size-1:0] e_dst       [rob_depth];
  logic                    e_set_nzcv  [rob_depth];
  logic                    e_uses_nzcv [rob_depth];
  logic                    a_valid     [rob_depth];
  logic [rob_idx_size-1:0] a_tag       [rob_depth];
  logic [gpr_size-1:0]     a_value     [rob_depth];
  logic                    b_valid     [rob_depth];
  logic [rob_idx_size-1:0] b_tag       [rob_depth];
  logic [gpr_size-1:0]     b_value     [rob_depth];
  logic                    f_valid     [rob_depth];
  logic [rob_idx_size-1:0] f_tag       [rob_depth];
  logic [nzcv_size-1:0]    f_value     [rob_depth];
  logic [gpr_size-1:0]     e_result    [rob_depth];
  logic [nzcv_size-1:0]    e_nzcv      [rob_depth];

  logic [rob_idx_size-1:0] head;
  logic [rob_idx_size-1:0] tail;
  logic [rob_idx_size:0]   count;
  logic [rob_idx_size-1:0] idx;

  // Dispatch operands after same-cycle broadcast and finished producers
  logic                    d_a_valid;
  logic [gpr_size-1:0]     d_a_value;
  logic                    d_b_valid;
  logic [gpr_size-1:0]     d_b_value;
  logic                    d_f_valid;
  logic [nzcv_size-1:0]    d_f_value;

  always_comb begin
    d_a_valid = 1'b1;
    d_a_value = src1_value;
    if (!src1_valid && res_valid && res_tag == src1_tag) begin
      d_a_value = res_value;
    end else if (!src1_valid && state[src1_tag] == ROB_DONE) begin
      d_a_value = e_result[src1_tag];
    end else begin
      d_a_valid = src1_valid;
    end

    d_b_valid = 1'b1;
    d_b_value = src2_value;
    if (!src2_valid && res_valid && res_tag == src2_tag) begin
      d_b_value = res_value;
    end else if (!src2_valid && state[src2_tag] == ROB_DONE) begin
      d_b_value = e_result[src2_tag];
    end else begin
      d_b_valid = src2_valid;
    end

    d_f_valid = 1'b1;
    d_f_value = nzcv_value;
    if (!nzcv_valid && res_valid && res_tag == nzcv_tag) begin
      d_f_value = res_nzcv;
    end else if (!nzcv_valid && state[nzcv_tag] == ROB_DONE) begin
      d_f_value = e_nzcv[nzcv_tag];
    end else begin
      d_f_valid = nzcv_valid;
    end
  end

  // Oldest ready entry, scanning from head
  always_comb begin
    iss_valid = 1'b0;
    iss_tag   = head;
    for (int i = 0; i < rob_depth; i++) begin
      idx = head + rob_idx_size'(i);
      if (!iss_valid && state[idx] == ROB_WAIT && a_valid[idx] && b_valid[idx] &&
          (f_valid[idx] || !e_uses_nzcv[idx])) begin
        iss_valid = 1'b1;
        iss_tag   = idx;
      end
    end
    iss_op    = e_op[iss_tag];
    iss_a     = a_value[iss_tag];
    iss_b     = b_value[iss_tag];
    iss_carry = f_value[iss_tag][nzcv_c_bit];
  end

  assign next_tag        = tail;
  assign instr_ready     = count < (rob_idx_size + 1)'(rob_depth - rob_reserve);
  assign commit_valid    = state[head] == ROB_DONE;
  assign commit_tag      = head;
  assign commit_reg      = e_dst[head];
  assign commit_value    = e_result[head];
  assign commit_set_nzcv = e_set_nzcv[head];
  assign commit_nzcv     = e_nzcv[head];

  always_ff @(posedge in_clk) begin
    if (in_rst) begin
      for (int i = 0; i < rob_depth; i++) begin
        state[i] <= ROB_FREE;
      end
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (ren_valid) begin
        state[tail] <= ROB_WAIT;
        tail        <= tail + 1'b1;
      end
      if (iss_valid) begin
        state[iss_tag] <= ROB_ISSUED;
      end
      if (res_valid) begin
        state[res_tag] <= ROB_DONE;
      end
      if (commit_valid) begin
        state[head] <= ROB_FREE;
        head        <= head + 1'b1;
      end
      case ({ren_valid, commit_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge in_clk) begin
    // Wakeup of waiting operands
    for (int i = 0; i < rob_depth; i++) begin
      if (res_valid && state[i] == ROB_WAIT) begin
        if (!a_valid[i] && a_tag[i] == res_tag) begin
          a_valid[i] <= 1'b1;
          a_value[i] <= res_value;
        end
        if (!b_valid[i] && b_tag[i] == res_tag) begin
          b_valid[i] <= 1'b1;
          b_value[i] <= res_value;
        end
        if (!f_valid[i] && f_tag[i] == res_tag) begin
          f_valid[i] <= 1'b1;
          f_value[i] <= res_nzcv;
        end
      end
    end
    if (ren_valid) begin
      e_op[tail]        <= op;
      e_dst[tail]       <= dst;
      e_set_nzcv[tail]  <= set_nzcv;
      e_uses_nzcv[tail] <= uses_nzcv;
      a_valid[tail]     <= d_a_valid;
      a_tag[tail]       <= src1_tag;
      a_value[tail]     <= d_a_value;
      b_valid[tail]     <= d_b_valid;
      b_tag[tail]       <= src2_tag;
      b_value[tail]     <= d_b_value;
      f_valid[tail]     <= d_f_valid;
      f_tag[tail]       <= nzcv_tag;
      f_value[tail]     <= d_f_value;
    end
    if (res_valid) begin
      e_result[res_tag] <= res_value;
      e_nzcv[res_tag]   <= res_nzcv;
    end
  end

  // The fetch side must stop before the tail wraps onto a live entry
  a_no_overflow : assert property (@(posedge in_clk) disable iff (in_rst)
    ren_valid |-> state[tail] == ROB_FREE);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f verilog.f

sim_out=$(./obj_dir/Vcore_tb)
echo "$sim_out"

if echo "$sim_out" | grep -q "TESTS PASSED"; then
  exit 0
fi
exit 1

// File: verification/core_checker.sv
module core_checker
  import core_pkg::*;
(
  input  logic                    in_clk,
  input  logic                    in_rst,
  input  logic                    commit_valid,
  input  logic [gpr_idx_size-1:0] commit_reg,
  input  logic [gpr_size-1:0]     commit_value,
  input  logic                    commit_set_nzcv,
  input  logic [nzcv_size-1:0]    commit_nzcv,
  output int                      error_count,
  output int                      left_over
);

  // Expected commit stream, oldest first
  string                   exp_name  [$];
  logic [gpr_idx_size-1:0] exp_reg   [$];
  logic [gpr_size-1:0]     exp_value [$];
  logic                    exp_set   [$];
  logic [nzcv_size-1:0]    exp_nzcv  [$];

  task automatic push_expected(input string name, input logic [gpr_idx_size-1:0] dst,
                               input logic [gpr_size-1:0] value, input logic set,
                               input logic [nzcv_size-1:0] nzcv);
    exp_name.push_back(name);
    exp_reg.push_back(dst);
    exp_value.push_back(value);
    exp_set.push_back(set);
    exp_nzcv.push_back(nzcv);
    left_over = exp_reg.size();
  endtask

  task automatic report_mismatch(input string name, input string field,
                                 input logic [gpr_size-1:0] expected,
                                 input logic [gpr_size-1:0] actual);
    $display("[FAIL] %s %s expected %h actual %h", name, field, expected, actual);
    error_count++;
  endtask

  task automatic check_commit();
    string                   name;
    logic                    set;
    logic [nzcv_size-1:0]    nzcv;
    name = exp_name.pop_front();
    set  = exp_set.pop_front();
    nzcv = exp_nzcv.pop_front();
    if (exp_reg[0] != commit_reg) begin
      report_mismatch(name, "dst", 32'(exp_reg[0]), 32'(commit_reg));
    end
    if (exp_value[0] != commit_value) begin
      report_mismatch(name, "value", exp_value[0], commit_value);
    end
    void'(exp_reg.pop_front());
    void'(exp_value.pop_front());
    if (set != commit_set_nzcv) begin
      report_mismatch(name, "set_nzcv", 32'(set), 32'(commit_set_nzcv));
    end else if (set && nzcv != commit_nzcv) begin
      report_mismatch(name, "nzcv", 32'(nzcv), 32'(commit_nzcv));
    end
  endtask

  // Commit outputs settle after the rising edge, so look mid-cycle
  always @(negedge in_clk) begin
    if (!in_rst && commit_valid) begin
      if (exp_reg.size() == 0) begin
        $display("Commit to r%0d arrived with no instruction left in the expected stream",
                 commit_reg);
        error_count++;
      end else begin
        check_commit();
      end
      left_over = exp_reg.size();
    end
  end

endmodule

// File: verification/core_tb.sv
module core_tb
  import core_pkg::*;
();

  localparam int n_entries      = 69;
  localparam int timeout_cycles = n_entries * 20 + 100;

  logic                    in_clk;
  logic                    in_rst;
  logic                    instr_valid;
  logic [instr_size-1:0]   instr;
  logic                    instr_ready;
  logic                    commit_valid;
  logic [gpr_idx_size-1:0] commit_reg;
  logic [gpr_size-1:0]     commit_value;
  logic                    commit_set_nzcv;
  logic [nzcv_size-1:0]    commit_nzcv;
  int                      chk_errors;
  int                      left_over;

  logic [instr_size-1:0]   tbl_instr [n_entries];
  string                   tbl_name  [n_entries];
  int                      n_built;
  logic [gpr_size-1:0]     model_reg [gpr_count];
  logic [nzcv_size-1:0]    model_flags;
  logic [15:0]             lfsr_state;
  int                      ready_low;
  int                      tb_errors;
  int                      cycles;

  ooo_core_top UUT (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .instr_ready    (instr_ready),
    .commit_valid   (commit_valid),
    .commit_reg     (commit_reg),
    .commit_value   (commit_value),
    .commit_set_nzcv(commit_set_nzcv),
    .commit_nzcv    (commit_nzcv)
  );

  core_checker u_check (
    .in_clk         (in_clk),
    .in_rst         (in_rst),
    .commit_valid   (commit_valid),
    .commit_reg     (commit_reg),
    .commit_value   (commit_value),
    .commit_set_nzcv(commit_set_nzcv),
    .commit_nzcv    (commit_nzcv),
    .error_count    (chk_errors),
    .left_over      (left_over)
  );

  initial begin
    in_clk = 1'b0;
    forever #10 in_clk = ~in_clk;
  end

  // Fibonacci LFSR, taps 16 14 13 11, one step per bit taken
  function automatic logic [31:0] lfsr_take(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      bits       = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // opcode, S, I, rd, rn, rm, spare bit, imm16
  function automatic logic [31:0] encode(input alu_op_t op, input logic s, input logic im,
                                         input logic [2:0] d, input logic [2:0] a,
                                         input logic [2:0] b, input logic [15:0] imm);
    return {op, s, im, d, a, b, 1'b0, imm};
  endfunction

  task automatic add_entry(input string name, input logic [31:0] word);
    tbl_instr[n_built] = word;
    tbl_name[n_built]  = name;
    n_built++;
  endtask

  task automatic build_table();
    alu_op_t     lop;
    logic [2:0]  prev;
    logic [2:0]  d;
    logic [31:0] rop;
    n_built = 0;
    for (int r = 0; r < gpr_count; r++) begin
      add_entry("mov_imm", encode(OP_MOV, 1'b0, 1'b1, 3'(r), 3'd0, 3'd0,
                                  16'h9000 + 16'(16'h0123 * r)));
    end
    add_entry("dep_chain", encode(OP_ADD, 1'b0, 1'b0, 3'd1, 3'd1, 3'd2, 16'h0));
    add_entry("dep_chain", encode(OP_SUB, 1'b0, 1'b0, 3'd1, 3'd1, 3'd3, 16'h0));
    add_entry("dep_chain", encode(OP_ADD, 1'b0, 1'b1, 3'd1, 3'd1, 3'd0, 16'h0fff));
    add_entry("dep_chain", encode(OP_SUB, 1'b0, 1'b0, 3'd1, 3'd1, 3'd4, 16'h0));
    add_entry("dep_chain", encode(OP_ADD, 1'b0, 1'b0, 3'd1, 3'd1, 3'd1, 16'h0));
    add_entry("dep_chain", encode(OP_SUB, 1'b0, 1'b1, 3'd1, 3'd1, 3'd0, 16'h0001));
    // r6 doubles 16 times up to 0x80000000, with unrelated logic ops in between
    add_entry("mix_indep", encode(OP_MOV, 1'b0, 1'b1, 3'd6, 3'd0, 3'd0, 16'h8000));
    for (int k = 0; k < 16; k++) begin
      add_entry("mix_indep", encode(OP_ADD, 1'b0, 1'b0, 3'd6, 3'd6, 3'd6, 16'h0));
      if (k % 2 == 0) begin
        lop = (k % 3 == 0) ? OP_AND : (k % 3 == 1) ? OP_ORR : OP_EOR;
        d   = (k % 4 == 0) ? 3'd7 : 3'd5;
        add_entry("mix_indep", encode(lop, 1'b0, 1'b0, d, 3'd2, 3'd3, 16'h0));
      end
    end
    add_entry("flags", encode(OP_MOV, 1'b1, 1'b1, 3'd0, 3'd0, 3'd0, 16'h0));
    add_entry("flags", encode(OP_SUB, 1'b1, 1'b0, 3'd1, 3'd0, 3'd0, 16'h0));
    add_entry("flags", encode(OP_ADC, 1'b0, 1'b1, 3'd2, 3'd0, 3'd0, 16'h0005));
    add_entry("flags", encode(OP_SUB, 1'b1, 1'b1, 3'd1, 3'd0, 3'd0, 16'h0001));
    add_entry("flags", encode(OP_ADC, 1'b0, 1'b1, 3'd2, 3'd0, 3'd0, 16'h0005));
    add_entry("flags", encode(OP_ADD, 1'b1, 1'b0, 3'd3, 3'd6, 3'd6, 16'h0));
    add_entry("flags", encode(OP_ADC, 1'b1, 1'b1, 3'd4, 3'd1, 3'd0, 16'h0));
    add_entry("flags", encode(OP_SUB, 1'b1, 1'b0, 3'd5, 3'd0, 3'd6, 16'h0));
    add_entry("flags", encode(OP_ADC, 1'b0, 1'b0, 3'd7, 3'd6, 3'd6, 16'h0));
    add_entry("waw_reg", encode(OP_ADD, 1'b0, 1'b0, 3'd2, 3'd6, 3'd6, 16'h0));
    add_entry("waw_reg", encode(OP_MOV, 1'b0, 1'b1, 3'd2, 3'd0, 3'd0, 16'h0777));
    add_entry("waw_reg", encode(OP_ADD, 1'b0, 1'b1, 3'd3, 3'd2, 3'd0, 16'h0001));
    add_entry("waw_reg", encode(OP_MOV, 1'b0, 1'b1, 3'd3, 3'd0, 3'd0, 16'h0042));
    add_entry("waw_reg", encode(OP_EOR, 1'b0, 1'b0, 3'd4, 3'd3, 3'd2, 16'h0));
    // Random burst, each word reads the previous destination
    prev = 3'd5;
    for (int k = 0; k < 16; k++) begin
      rop = lfsr_take(3);
      if (rop > 6) begin
        rop = 0;
      end
      d = 3'(lfsr_take(3));
      add_entry("burst", encode(alu_op_t'(rop[3:0]), lfsr_take(1) != 0, lfsr_take(1) != 0,
                                d, prev, 3'(lfsr_take(3)), 16'(lfsr_take(16))));
      prev = d;
    end
  endtask

  // In-order reference, straight from the instruction rules
  task automatic model_step(input logic [31:0] word, input string name);
    logic [3:0]  opc;
    logic [2:0]  d;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [32:0] wide;
    logic        c;
    logic        v;
    opc = word[31:28];
    d   = word[25:23];
    a   = model_reg[word[22:20]];
    b   = word[26] ? {16'h0, word[15:0]} : model_reg[word[19:17]];
    c   = 1'b0;
    v   = 1'b0;
    case (opc)
      OP_ADD, OP_ADC: begin
        wide = {1'b0, a} + {1'b0, b} + ((opc == OP_ADC) ? {32'h0, model_flags[1]} : 33'h0);
        r    = wide[31:0];
        c    = wide[32];
        v    = (a[31] == b[31]) && (r[31] != a[31]);
      end
      OP_SUB: begin
        r = a - b;
        c = (a >= b);
        v = (a[31] != b[31]) && (r[31] != a[31]);
      end
      OP_AND:  r = a & b;
      OP_ORR:  r = a | b;
      OP_EOR:  r = a ^ b;
      default: r = b;
    endcase
    model_reg[d] = r;
    if (word[27]) begin
      model_flags = {r[31], r == 32'h0, c, v};
    end
    u_check.push_expected(name, d, r, word[27], {r[31], r == 32'h0, c, v});
  endtask

  // Holds the word until a rising edge sees instr_ready high
  task automatic send_instr(input logic [31:0] word);
    logic taken;
    taken       = 1'b0;
    instr_valid = 1'b1;
    instr       = word;
    while (!taken) begin
      @(negedge in_clk);
      taken = instr_ready;
      if (!taken) begin
        ready_low++;
      end
      @(posedge in_clk);
      #2;
    end
    instr_valid = 1'b0;
  endtask

  initial begin
    cycles = 0;
    while (cycles < timeout_cycles) begin
      @(posedge in_clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d expected commits never arrived",
             cycles, left_over);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    in_rst      = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    lfsr_state  = 16'd42;
    ready_low   = 0;
    tb_errors   = 0;
    model_flags = '0;
    for (int r = 0; r < gpr_count; r++) begin
      model_reg[r] = '0;
    end
    build_table();
    for (int t = 0; t < n_entries; t++) begin
      model_step(tbl_instr[t], tbl_name[t]);
    end
    repeat (5) @(posedge in_clk);
    #2;
    in_rst = 1'b0;
    for (int t = 0; t < n_entries; t++) begin
      send_instr(tbl_instr[t]);
    end
    while (left_over != 0) begin
      @(posedge in_clk);
    end
    // Catch any stray commit after the last expected one
    repeat (10) @(posedge in_clk);
    if (ready_low == 0) begin
      $display("instr_ready never went low, so the buffer was never filled");
      tb_errors++;
    end
    $display("Run complete: %0d commit errors, %0d other errors", chk_errors, tb_errors);
    if (chk_errors + tb_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
hdl/core_pkg.sv
hdl/instr_decoder.sv
hdl/reg_rename.sv
hdl/reorder_buffer.sv
hdl/alu_unit.sv
hdl/ooo_core_top.sv
verification/core_checker.sv
verification/core_tb.sv
